// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	typedef logic [31:0] word_t;      // data word
	typedef logic [4:0]  reg_addr_t;  // register number
	typedef logic [5:0]  opcode_t;    // insn[31:26]
	typedef logic [3:0]  alu_op_t;    // alu or shifter operation
	typedef logic [1:0]  mem_op_t;    // memory access kind
	typedef logic        ex_out_sel_t; // which execute unit drives result

	// ------------------------------
	// opcodes
	// ------------------------------
	// register format, dst in rd
	localparam opcode_t OP_ADD  = 6'h01;
	localparam opcode_t OP_SUB  = 6'h02;
	localparam opcode_t OP_AND  = 6'h03;
	localparam opcode_t OP_OR   = 6'h04;
	localparam opcode_t OP_XOR  = 6'h05;
	localparam opcode_t OP_SLL  = 6'h06;
	localparam opcode_t OP_SRL  = 6'h07;
	localparam opcode_t OP_SRA  = 6'h08;
	// immediate format, dst in rb
	localparam opcode_t OP_ADDI = 6'h10;
	localparam opcode_t OP_LDW  = 6'h11;
	localparam opcode_t OP_STW  = 6'h12;

	// execute operations
	localparam alu_op_t ALU_OP_NOP = 4'h0;
	localparam alu_op_t ALU_OP_ADD = 4'h1;
	localparam alu_op_t ALU_OP_SUB = 4'h2;
	localparam alu_op_t ALU_OP_AND = 4'h3;
	localparam alu_op_t ALU_OP_OR  = 4'h4;
	localparam alu_op_t ALU_OP_XOR = 4'h5;
	localparam alu_op_t ALU_OP_SLL = 4'h6; // shifter ops from here
	localparam alu_op_t ALU_OP_SRL = 4'h7;
	localparam alu_op_t ALU_OP_SRA = 4'h8;

	localparam mem_op_t MEM_OP_NOP = 2'd0;
	localparam mem_op_t MEM_OP_LDW = 2'd1;
	localparam mem_op_t MEM_OP_STW = 2'd2;

	localparam ex_out_sel_t EX_SEL_ALU   = 1'b0;
	localparam ex_out_sel_t EX_SEL_SHIFT = 1'b1;

	// ------------------------------
	// stage bundles
	// ------------------------------
	typedef struct packed {
		logic        en;          // stage valid
		alu_op_t     alu_op;
		word_t       alu_in_0;
		word_t       alu_in_1;
		mem_op_t     mem_op;
		word_t       mem_wr_data; // store data
		reg_addr_t   dst_addr;
		logic        gpr_we_n;    // active low
		ex_out_sel_t gpr_mux_ex;
		logic        gpr_mux_mem; // take loaded value at writeback
	} id_bundle_t;

	typedef struct packed {
		logic      en;
		word_t     result;        // also the load/store address
		mem_op_t   mem_op;
		word_t     mem_wr_data;
		reg_addr_t dst_addr;
		logic      gpr_we_n;
		logic      gpr_mux_mem;
	} ex_bundle_t;

	// bubbles, same as reset contents
	localparam id_bundle_t ID_BUBBLE = '{
		en:          1'b0,
		alu_op:      ALU_OP_NOP,
		alu_in_0:    '0,
		alu_in_1:    '0,
		mem_op:      MEM_OP_NOP,
		mem_wr_data: '0,
		dst_addr:    '0,
		gpr_we_n:    1'b1,
		gpr_mux_ex:  EX_SEL_ALU,
		gpr_mux_mem: 1'b0
	};

	localparam ex_bundle_t EX_BUBBLE = '{
		en:          1'b0,
		result:      '0,
		mem_op:      MEM_OP_NOP,
		mem_wr_data: '0,
		dst_addr:    '0,
		gpr_we_n:    1'b1,
		gpr_mux_mem: 1'b0
	};

endpackage

// ==== source/id_decoder.sv ====
`timescale 1ns/10ps

module id_decoder
	import cpu_pkg::*;
(
	input  logic       if_en,     // fetch word valid
	input  word_t      insn,
	input  word_t      rs_data_0, // value of ra
	input  word_t      rs_data_1, // value of rb
	output id_bundle_t id_next
);

	// ------------------------------
	// field split
	// ------------------------------
	opcode_t   opcode;
	reg_addr_t rb;      // dst for immediate ops
	reg_addr_t rd;      // dst for register ops
	word_t     imm_ext; // sign extended imm

	alu_op_t   op_sel;  // operation from opcode
	logic      fmt_reg; // register format op
	logic      fmt_imm; // immediate format op
	logic      is_shift;

	// ra and rb already went to the register file upstream
	assign opcode  = insn[31:26];
	assign rb      = insn[20:16];
	assign rd      = insn[15:11];
	assign imm_ext = {{16{insn[15]}}, insn[15:0]};

	// opcode -> operation and format
	always_comb begin
		op_sel  = ALU_OP_NOP;
		fmt_reg = 1'b0;
		fmt_imm = 1'b0;
		case (opcode)
			OP_ADD: begin
				op_sel  = ALU_OP_ADD;
				fmt_reg = 1'b1;
			end
			OP_SUB: begin
				op_sel  = ALU_OP_SUB;
				fmt_reg = 1'b1;
			end
			OP_AND: begin
				op_sel  = ALU_OP_AND;
				fmt_reg = 1'b1;
			end
			OP_OR: begin
				op_sel  = ALU_OP_OR;
				fmt_reg = 1'b1;
			end
			OP_XOR: begin
				op_sel  = ALU_OP_XOR;
				fmt_reg = 1'b1;
			end
			OP_SLL: begin
				op_sel  = ALU_OP_SLL;
				fmt_reg = 1'b1;
			end
			OP_SRL: begin
				op_sel  = ALU_OP_SRL;
				fmt_reg = 1'b1;
			end
			OP_SRA: begin
				op_sel  = ALU_OP_SRA;
				fmt_reg = 1'b1;
			end
			OP_ADDI, OP_LDW, OP_STW: begin
				op_sel  = ALU_OP_ADD; // address or sum = ra + imm
				fmt_imm = 1'b1;
			end
			default: ;                // nop or unknown, stays cleared
		endcase
	end

	assign is_shift = (op_sel == ALU_OP_SLL) || (op_sel == ALU_OP_SRL) ||
	                  (op_sel == ALU_OP_SRA);

	// ------------------------------
	// bundle build
	// ------------------------------
	always_comb begin
		id_next = ID_BUBBLE; // default is a bubble with write off
		if (if_en && (fmt_reg || fmt_imm)) begin
			id_next.en         = 1'b1;
			id_next.alu_op     = op_sel;
			id_next.alu_in_0   = rs_data_0;
			id_next.alu_in_1   = fmt_imm ? imm_ext : rs_data_1; // shifter uses low 5 bits
			id_next.gpr_mux_ex = is_shift ? EX_SEL_SHIFT : EX_SEL_ALU;
			id_next.gpr_we_n   = 1'b0;
			id_next.dst_addr   = fmt_imm ? rb : rd;
			case (opcode)
				OP_LDW: begin
					id_next.mem_op      = MEM_OP_LDW;
					id_next.gpr_mux_mem = 1'b1;  // writeback from memory
				end
				OP_STW: begin
					id_next.mem_op      = MEM_OP_STW;
					id_next.mem_wr_data = rs_data_1;
					id_next.gpr_we_n    = 1'b1;  // store writes no register
					id_next.dst_addr    = '0;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== source/id_reg.sv ====
`timescale 1ns/10ps

module id_reg
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       stall,   // hold current contents
	input  logic       flush,   // drop current instruction
	input  id_bundle_t id_next, // from decoder
	output id_bundle_t id_q     // to execute
);

	// ------------------------------
	// decode/execute stage register
	// ------------------------------
	// stall wins over flush
	// a stalled instruction stays here and issues once stall drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_q <= ID_BUBBLE;      // en 0, write off
		end else if (!stall) begin
			if (flush) begin
				id_q <= ID_BUBBLE;  // kill the incoming instruction
			end else begin
				id_q <= id_next;
			end
		end
		// stall high keeps id_q as it is
	end

endmodule

// ==== source/ex_alu.sv ====
`timescale 1ns/10ps

module ex_alu
	import cpu_pkg::*;
(
	input  id_bundle_t id_q,
	output word_t      alu_result
);

	word_t a; // operand 0
	word_t b; // operand 1, imm for immediate ops

	assign a = id_q.alu_in_0;
	assign b = id_q.alu_in_1;

	// ------------------------------
	// arithmetic and logic
	// ------------------------------
	always_comb begin
		case (id_q.alu_op)
			ALU_OP_ADD: alu_result = a + b; // wraps, no overflow flag
			ALU_OP_SUB: alu_result = a - b;
			ALU_OP_AND: alu_result = a & b;
			ALU_OP_OR:  alu_result = a | b;
			ALU_OP_XOR: alu_result = a ^ b;
			default:    alu_result = '0;    // shifts and nop
		endcase
	end

endmodule

// ==== source/ex_shift.sv ====
`timescale 1ns/10ps

module ex_shift
	import cpu_pkg::*;
(
	input  id_bundle_t id_q,
	output word_t      shift_result
);

	logic [4:0] shamt; // 0..31

	assign shamt = id_q.alu_in_1[4:0];

	// ------------------------------
	// barrel shifter
	// ------------------------------
	always_comb begin
		case (id_q.alu_op)
			ALU_OP_SLL: shift_result = id_q.alu_in_0 << shamt;
			ALU_OP_SRL: shift_result = id_q.alu_in_0 >> shamt;  // zero fill
			ALU_OP_SRA: shift_result = word_t'($signed(id_q.alu_in_0) >>> shamt); // sign fill
			default:    shift_result = '0;
		endcase
	end

endmodule

// ==== source/ex_reg.sv ====
`timescale 1ns/10ps

module ex_reg
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       stall,        // execute gets a bubble
	input  id_bundle_t id_q,
	input  word_t      alu_result,
	input  word_t      shift_result,
	output ex_bundle_t ex_out
);

	word_t result_sel; // unit chosen by gpr_mux_ex

	assign result_sel = (id_q.gpr_mux_ex == EX_SEL_SHIFT) ? shift_result : alu_result;

	// ------------------------------
	// execute/memory stage register
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_out <= EX_BUBBLE;
		end else if (stall) begin
			// id_q is held, so do not issue it twice
			ex_out <= EX_BUBBLE;
		end else begin
			ex_out.en          <= id_q.en;
			ex_out.result      <= result_sel;    // address for ldw/stw
			ex_out.mem_op      <= id_q.mem_op;
			ex_out.mem_wr_data <= id_q.mem_wr_data;
			ex_out.dst_addr    <= id_q.dst_addr;
			ex_out.gpr_we_n    <= id_q.gpr_we_n;
			ex_out.gpr_mux_mem <= id_q.gpr_mux_mem;
		end
	end

endmodule

// ==== source/id_ex_core.sv ====
`timescale 1ns/10ps

module id_ex_core
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       if_en,     // insn valid
	input  logic       stall,
	input  logic       flush,
	input  word_t      insn,
	input  word_t      rs_data_0,
	input  word_t      rs_data_1,
	output ex_bundle_t ex_out     // two edges after insn
);

	// ------------------------------
	// internal stage signals
	// ------------------------------
	id_bundle_t id_next;      // decoder out
	id_bundle_t id_q;         // registered decode
	word_t      alu_result;
	word_t      shift_result;

	id_decoder u_id_decoder (
		.if_en     (if_en),
		.insn      (insn),
		.rs_data_0 (rs_data_0),
		.rs_data_1 (rs_data_1),
		.id_next   (id_next)
	);

	id_reg u_id_reg (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.flush   (flush),
		.id_next (id_next),
		.id_q    (id_q)
	);

	// both units see the same bundle, ex_reg picks one
	ex_alu u_ex_alu (
		.id_q       (id_q),
		.alu_result (alu_result)
	);

	ex_shift u_ex_shift (
		.id_q         (id_q),
		.shift_result (shift_result)
	);

	ex_reg u_ex_reg (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall        (stall),
		.id_q         (id_q),
		.alu_result   (alu_result),
		.shift_result (shift_result),
		.ex_out       (ex_out)
	);

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;        // release on the 16th rising edge
	end

endmodule

// ==== verification/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       if_en,
	input  logic       stall,
	input  logic       flush,
	input  word_t      insn,
	input  word_t      rs_data_0,
	input  word_t      rs_data_1,
	input  logic       active,      // a table entry is on the inputs
	input  int         test_idx,
	input  ex_bundle_t ex_out,
	output int         error_count,
	output int         check_count,
	output logic       busy         // tagged entries still in flight
);

	typedef struct packed {
		ex_bundle_t b;
		int         idx;
		logic       tag;
	} slot_t;

	slot_t id_slot; // model of id_reg
	slot_t ex_slot; // model of ex_out

	// ------------------------------
	// expected execute bundle
	// ------------------------------
	function automatic ex_bundle_t predict(logic v, word_t i, word_t a, word_t b);
		ex_bundle_t e;
		word_t      imm;
		logic [4:0] s;
		opcode_t    op;
		e   = EX_BUBBLE;
		op  = i[31:26];
		imm = {{16{i[15]}}, i[15:0]};
		s   = b[4:0];   // shift amount
		if (v) begin
			e.en       = 1'b1;
			e.gpr_we_n = 1'b0;
			e.dst_addr = i[15:11];
			case (op)
				OP_ADD: e.result = a + b;
				OP_SUB: e.result = a - b;
				OP_AND: e.result = a & b;
				OP_OR:  e.result = a | b;
				OP_XOR: e.result = a ^ b;
				OP_SLL: e.result = a << s;
				OP_SRL: e.result = a >> s;
				OP_SRA: e.result = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
				OP_ADDI, OP_LDW, OP_STW: begin
					e.result   = a + imm;   // sum or address
					e.dst_addr = i[20:16];
				end
				default: e = EX_BUBBLE;  // unknown -> bubble
			endcase
			if (op == OP_LDW) begin
				e.mem_op      = MEM_OP_LDW;
				e.gpr_mux_mem = 1'b1;
			end
			if (op == OP_STW) begin
				e.mem_op      = MEM_OP_STW;
				e.mem_wr_data = b;
				e.gpr_we_n    = 1'b1;
				e.dst_addr    = '0;
			end
		end
		return e;
	endfunction

	assign busy = id_slot.tag || ex_slot.tag;

	// two-deep model, advanced on the same edge as the DUT
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_slot <= '{b: EX_BUBBLE, idx: 0, tag: 1'b0};
			ex_slot <= '{b: EX_BUBBLE, idx: 0, tag: 1'b0};
		end else begin
			if (stall) begin
				ex_slot <= '{b: EX_BUBBLE, idx: test_idx, tag: active};
			end else begin
				ex_slot <= id_slot;
				if (flush)
					id_slot <= '{b: EX_BUBBLE, idx: test_idx, tag: active};
				else
					id_slot <= '{b: predict(if_en, insn, rs_data_0, rs_data_1),
					             idx: test_idx, tag: active};
			end
		end
	end

	initial begin
		error_count = 0;
		check_count = 0;
	end

	// ------------------------------
	// compare on the falling edge
	// ------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (ex_slot.tag) begin
				check_count++;
				if (ex_out !== ex_slot.b) begin
					error_count++;
					$display("FAILED %0s expected %h actual %h",
					         tb_top.test_name[ex_slot.idx], ex_slot.b, ex_out);
				end else begin
					$display("ok     %0s result %h", tb_top.test_name[ex_slot.idx], ex_out.result);
				end
			end else if (ex_out !== ex_slot.b) begin
				error_count++;   // idle slot must stay a bubble
				$display("FAILED idle_bubble expected %h actual %h", ex_slot.b, ex_out);
			end
		end
	end

endmodule

// ==== verification/id_ex_asserts.sv ====
`timescale 1ns/10ps

module id_ex_asserts
	import cpu_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       stall,
	input ex_bundle_t ex_out
);

	// a bubble never writes a register or touches memory
	a_bubble_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!ex_out.en |-> (ex_out.gpr_we_n && ex_out.mem_op == MEM_OP_NOP))
		else $error("bubble on ex_out with write or memory op active");

	// stall puts a bubble into execute on the next edge
	a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> !ex_out.en)
		else $error("ex_out valid one cycle after stall");

endmodule

bind ex_reg id_ex_asserts u_asserts (
	.clk(clk), .rst_n(rst_n), .stall(stall), .ex_out(ex_out)
);

// ==== verification/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;
	import cpu_pkg::*;

	logic       clk;
	logic       rst_n;
	logic       if_en;
	logic       stall;
	logic       flush;
	logic       active;
	int         test_idx;
	word_t      insn;
	word_t      rs_data_0;
	word_t      rs_data_1;
	ex_bundle_t ex_out;
	int         error_count;
	int         check_count;
	logic       busy;

	// ------------------------------
	// stimulus table
	// ------------------------------
	string test_name [40];
	word_t t_insn    [40];
	word_t t_a       [40];
	word_t t_b       [40];
	logic  t_en      [40];
	logic  t_stall   [40];
	logic  t_flush   [40];
	int    n_tests;
	int    seed;
	int    cycles;
	logic  timed_out;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	id_ex_core uut (
		.clk(clk), .rst_n(rst_n), .if_en(if_en), .stall(stall), .flush(flush),
		.insn(insn), .rs_data_0(rs_data_0), .rs_data_1(rs_data_1), .ex_out(ex_out)
	);

	tb_checker u_checker (
		.clk(clk), .rst_n(rst_n), .if_en(if_en), .stall(stall), .flush(flush),
		.insn(insn), .rs_data_0(rs_data_0), .rs_data_1(rs_data_1), .active(active),
		.test_idx(test_idx), .ex_out(ex_out), .error_count(error_count),
		.check_count(check_count), .busy(busy)
	);

	function automatic word_t r_insn(opcode_t op, reg_addr_t rd);
		return {op, 5'd1, 5'd2, rd, 11'd0};
	endfunction

	function automatic word_t i_insn(opcode_t op, reg_addr_t rb, logic [15:0] imm);
		return {op, 5'd1, rb, imm};
	endfunction

	task automatic add_test(string nm, word_t i, word_t a, word_t b, logic en, logic st,
	                        logic fl);
		test_name[n_tests] = nm;
		t_insn[n_tests]    = i;
		t_a[n_tests]       = a;
		t_b[n_tests]       = b;
		t_en[n_tests]      = en;
		t_stall[n_tests]   = st;
		t_flush[n_tests]   = fl;
		n_tests++;
	endtask

	initial begin
		if_en = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		active = 1'b0;
		test_idx = 0;
		insn = '0;
		rs_data_0 = '0;
		rs_data_1 = '0;
		n_tests = 0;
		seed = 28;
		timed_out = 1'b0;

		add_test("add_basic", r_insn(OP_ADD, 5'd3), 32'd5, 32'd7, 1, 0, 0);
		add_test("sub_neg", r_insn(OP_SUB, 5'd4), 32'd3, 32'd10, 1, 0, 0);
		add_test("and_mask", r_insn(OP_AND, 5'd5), 32'hf0f0_1234, 32'h0ff0_ffff, 1, 0, 0);
		add_test("or_bits", r_insn(OP_OR, 5'd6), 32'h8000_0001, 32'h0000_0f00, 1, 0, 0);
		add_test("xor_bits", r_insn(OP_XOR, 5'd7), 32'haaaa_5555, 32'hffff_0000, 1, 0, 0);
		add_test("add_wrap", r_insn(OP_ADD, 5'd31), 32'hffff_ffff, 32'd2, 1, 0, 0);
		add_test("rand_add", r_insn(OP_ADD, 5'd8), $random(seed), $random(seed), 1, 0, 0);
		add_test("rand_sub", r_insn(OP_SUB, 5'd9), $random(seed), $random(seed), 1, 0, 0);
		add_test("rand_and", r_insn(OP_AND, 5'd10), $random(seed), $random(seed), 1, 0, 0);
		add_test("rand_or", r_insn(OP_OR, 5'd11), $random(seed), $random(seed), 1, 0, 0);
		add_test("rand_xor", r_insn(OP_XOR, 5'd12), $random(seed), $random(seed), 1, 0, 0);
		add_test("sll_0", r_insn(OP_SLL, 5'd13), 32'h1234_5678, 32'd0, 1, 0, 0);
		add_test("sll_31", r_insn(OP_SLL, 5'd14), 32'h0000_0003, 32'd31, 1, 0, 0);
		add_test("srl_neg31", r_insn(OP_SRL, 5'd15), 32'h8000_0000, 32'd31, 1, 0, 0);
		add_test("srl_hi_amt", r_insn(OP_SRL, 5'd16), 32'hf000_0000, 32'hffff_ffe4, 1, 0, 0);
		add_test("sra_neg", r_insn(OP_SRA, 5'd17), 32'h8000_00f0, 32'd4, 1, 0, 0);
		add_test("sra_31", r_insn(OP_SRA, 5'd18), 32'h9000_0000, 32'd31, 1, 0, 0);
		add_test("sra_pos", r_insn(OP_SRA, 5'd19), 32'h7000_0000, 32'd8, 1, 0, 0);
		add_test("addi_neg", i_insn(OP_ADDI, 5'd20, 16'hfff0), 32'd100, 32'd0, 1, 0, 0);
		add_test("ldw", i_insn(OP_LDW, 5'd21, 16'h0010), 32'h0000_1000, 32'd0, 1, 0, 0);
		add_test("stw", i_insn(OP_STW, 5'd22, 16'h8004), 32'h0001_0000, 32'hdead_beef, 1, 0, 0);
		// held in id_reg across three stall cycles
		add_test("stall_held", r_insn(OP_ADD, 5'd23), 32'd40, 32'd2, 1, 0, 0);
		add_test("stall_1", r_insn(OP_SUB, 5'd1), 32'd1, 32'd1, 1, 1, 0);
		add_test("stall_2", r_insn(OP_SUB, 5'd1), 32'd1, 32'd1, 1, 1, 0);
		add_test("stall_3", r_insn(OP_SUB, 5'd1), 32'd1, 32'd1, 1, 1, 0);
		add_test("after_stall", r_insn(OP_XOR, 5'd24), 32'd6, 32'd3, 1, 0, 0);
		add_test("flush_drop", r_insn(OP_ADD, 5'd25), 32'd9, 32'd9, 1, 0, 1);
		add_test("after_flush", r_insn(OP_OR, 5'd26), 32'd8, 32'd1, 1, 0, 0);
		add_test("if_en_low", r_insn(OP_ADD, 5'd27), 32'd1, 32'd2, 0, 0, 0);
		add_test("bad_opcode", r_insn(6'h3f, 5'd28), 32'd1, 32'd2, 1, 0, 0);

		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 100) begin
			@(posedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			timed_out = 1'b1;
			$display("timeout: reset was never released");
		end

		if (!timed_out) begin
			for (int i = 0; i < n_tests; i++) begin
				@(posedge clk);
				active    <= 1'b1;
				test_idx  <= i;
				insn      <= t_insn[i];
				rs_data_0 <= t_a[i];
				rs_data_1 <= t_b[i];
				if_en     <= t_en[i];
				stall     <= t_stall[i];
				flush     <= t_flush[i];
			end
			@(posedge clk);
			active <= 1'b0;  // idle inputs while the pipe drains
			if_en  <= 1'b0;
			stall  <= 1'b0;
			flush  <= 1'b0;

			cycles = 0;
			@(posedge clk);
			while (busy && cycles < 20) begin
				@(posedge clk);
				cycles++;
			end
			if (busy) begin
				timed_out = 1'b1;
				$display("timeout: pipeline did not drain after the last test");
			end
		end

		@(negedge clk);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (check_count != n_tests) begin
			$display("not every test was checked on ex_out");
		end
		if (timed_out || error_count != 0 || check_count != n_tests) begin
			$display("ERRORS FOUND");
		end else begin
			$display("NO ERRORS");
		end
		$finish;
	end

endmodule

// ==== files.f ====
source/cpu_pkg.sv
source/id_decoder.sv
source/id_reg.sv
source/ex_alu.sv
source/ex_shift.sv
source/ex_reg.sv
source/id_ex_core.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/id_ex_asserts.sv
verification/tb_top.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_top -f files.f

sim:
	verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f files.f
	./obj_dir/Vtb_top | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
